/* verilog/pc_pkg.sv */
package pc_pkg;

	typedef logic [7:0] byte_t;     // Data byte, also one half of the PC
	typedef logic [15:0] addr_t;
	typedef logic [7:0] opcode_t;

	// One Wishbone access per timing state
	typedef enum logic [1:0] {
		t0,     // Opcode fetch
		t1,
		t2,
		t3
	} cycle_t;

	localparam opcode_t op_nop = 8'hea;
	localparam opcode_t op_jmp_abs = 8'h4c;
	localparam opcode_t op_bcc = 8'h90;
	localparam opcode_t op_bcs = 8'hb0;

	// Decode lines from the instruction register and timing state
	typedef struct packed {
		logic jmp_t1;   // JMP fetching the low operand
		logic jmp_t2;   // JMP fetching the high operand and loading the PC
		logic br_t1;    // Branch fetching its offset
		logic br_taken; // Branch sense, taken on carry set
		logic br_fix;   // Branch page correction cycle
	} decode_t;

endpackage

/* verilog/pc_bus_if.sv */
interface pc_bus_if;

	logic pcl_inc;
	logic adl_pcl;
	logic pch_inc;
	logic pch_dec;
	logic dl_pch;
	logic adh_pch;
	logic pcl_carry;

	modport ctrl (
		output pcl_inc, adl_pcl, pch_inc, pch_dec, dl_pch, adh_pch,
		input pcl_carry
	);

	// PCL adds the branch offset when pcl_inc and adl_pcl are raised together
	modport low (
		input pcl_inc, adl_pcl,
		output pcl_carry
	);

	modport high (
		input pcl_inc, pch_inc, pch_dec, dl_pch, adh_pch, pcl_carry
	);

endinterface

/* verilog/opcode_decode.sv */
module opcode_decode import pc_pkg::*; (
	input logic phi2,
	input logic rst_n,
	input logic advance,
	input cycle_t cycle,
	input byte_t dat,
	output decode_t dec
);

	opcode_t ir;
	logic is_jmp;
	logic is_branch;
	logic is_bcs;

	// The opcode byte sits in the data latch during the cycle after the t0 ack
	always_ff @(posedge phi2 or negedge rst_n) begin
		if (!rst_n) begin
			ir <= op_nop;
		end else if (advance && cycle == t0) begin
			ir <= dat;
		end
	end

	assign is_jmp = (ir == op_jmp_abs);
	assign is_bcs = (ir == op_bcs);
	assign is_branch = (ir == op_bcc) || is_bcs;

	// Anything unknown decodes to no lines at all and runs as a NOP
	always_comb begin
		dec = '0;
		dec.jmp_t1 = is_jmp && (cycle == t1);
		dec.jmp_t2 = is_jmp && (cycle == t2);
		dec.br_t1 = is_branch && (cycle == t1);
		dec.br_taken = is_branch && is_bcs;     // BCC is taken on carry clear
		dec.br_fix = is_branch && (cycle == t3);
	end

endmodule

/* verilog/pc_control.sv */
module pc_control import pc_pkg::*; (
	input logic phi2,
	input logic rst_n,
	input logic advance,
	input logic flag_c,
	input decode_t dec,
	output cycle_t cycle,
	output logic sync,
	pc_bus_if.ctrl pcb
);

	cycle_t cycle_next;
	logic running;
	logic taken;

	// Condition code against the opcode sense
	assign taken = dec.br_t1 && (flag_c == dec.br_taken);

	always_ff @(posedge phi2 or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= t0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;    // Rises with the first request
			if (advance) begin
				cycle <= cycle_next;
			end
		end
	end

	assign sync = running && (cycle == t0);

	always_comb begin
		cycle_next = t0;
		case (cycle)
			t0: cycle_next = t1;
			t1: begin
				if (dec.jmp_t1 || taken) begin
					cycle_next = t2;
				end
			end
			t2: begin
				// Only a taken branch can cross a page here
				if (!dec.jmp_t2 && pcb.pcl_carry) begin
					cycle_next = t3;
				end
			end
			default: cycle_next = t0;
		endcase
	end

	// With no strobe raised both halves hold
	always_comb begin
		pcb.pcl_inc = 1'b0;
		pcb.adl_pcl = 1'b0;
		pcb.pch_inc = 1'b0;
		pcb.pch_dec = 1'b0;
		pcb.dl_pch = 1'b0;
		pcb.adh_pch = 1'b0;
		case (cycle)
			t0: pcb.pcl_inc = 1'b1;
			t1: pcb.pcl_inc = dec.jmp_t1 || dec.br_t1;
			t2: begin
				if (dec.jmp_t2) begin
					pcb.adl_pcl = 1'b1;
					pcb.dl_pch = 1'b1;
				end else begin
					// Offset add on PCL while PCH goes round through ADH
					pcb.pcl_inc = 1'b1;
					pcb.adl_pcl = 1'b1;
					pcb.adh_pch = 1'b1;
				end
			end
			t3: begin
				pcb.pch_inc = dec.br_fix && pcb.pcl_carry;
				pcb.pch_dec = dec.br_fix && !pcb.pcl_carry;
			end
			default: ;
		endcase
	end

endmodule

/* verilog/pc_low.sv */
module pc_low import pc_pkg::*; #(
	parameter byte_t RESET_LOW = 8'h00
) (
	input logic phi2,
	input logic rst_n,
	input logic advance,
	input byte_t adl,
	input byte_t offset,
	pc_bus_if.low pcb,
	output byte_t pcl
);

	logic add;
	logic [8:0] sum;
	logic carry_q;

	assign add = pcb.pcl_inc && pcb.adl_pcl;

	always_comb begin
		if (add) begin
			sum = {1'b0, pcl} + {1'b0, offset};
		end else begin
			sum = {1'b0, pcl} + 9'd1;
		end
	end

	// A negative offset crosses the page when the unsigned add does not carry
	always_comb begin
		if (add) begin
			pcb.pcl_carry = sum[8] ^ offset[7];
		end else if (pcb.pcl_inc) begin
			pcb.pcl_carry = sum[8];     // Rolling over from FF
		end else begin
			pcb.pcl_carry = carry_q;    // Set for carry, clear for borrow
		end
	end

	always_ff @(posedge phi2 or negedge rst_n) begin
		if (!rst_n) begin
			pcl <= RESET_LOW;
			carry_q <= 1'b0;
		end else if (advance) begin
			if (pcb.pcl_inc) begin
				pcl <= sum[7:0];
			end else if (pcb.adl_pcl) begin
				pcl <= adl;
			end
			if (add) begin
				carry_q <= sum[8];
			end
		end
	end

endmodule

/* verilog/pc_high.sv */
module pc_high import pc_pkg::*; #(
	parameter byte_t RESET_HIGH = 8'h02
) (
	input logic phi2,
	input logic rst_n,
	input logic advance,
	input byte_t dl,
	input byte_t adh,
	pc_bus_if.high pcb,
	output byte_t pch
);

	logic step_up;
	logic step_down;

	// Carry from the PCL incrementer, or the page fix after a forward branch
	assign step_up = pcb.pch_inc || (pcb.pcl_inc && pcb.pcl_carry);
	assign step_down = pcb.pch_dec;

	// Loads win over the carry so the offset add never touches PCH
	always_ff @(posedge phi2 or negedge rst_n) begin
		if (!rst_n) begin
			pch <= RESET_HIGH;
		end else if (advance) begin
			if (pcb.dl_pch) begin
				pch <= dl;
			end else if (pcb.adh_pch) begin
				pch <= adh;
			end else if (step_up) begin
				pch <= pch + 8'd1;
			end else if (step_down) begin
				pch <= pch - 8'd1;
			end
		end
	end

endmodule

/* verilog/bus_master.sv */
module bus_master import pc_pkg::*; (
	input logic phi2,
	input logic rst_n,
	input addr_t pc,
	input cycle_t cycle,
	output addr_t adr,
	output logic cyc,
	output logic stb,
	output logic we,
	input logic ack,
	input byte_t dat_i,
	output byte_t dl,
	output byte_t adl,
	output logic advance
);

	logic req;
	logic done;

	assign done = req && ack;

	// One idle cycle after every ack, during which the rest of the design steps
	always_ff @(posedge phi2 or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
			advance <= 1'b0;
		end else begin
			advance <= done;
			if (done) begin
				req <= 1'b0;
			end else if (!req) begin
				req <= 1'b1;
			end
		end
	end

	// The t1 byte is the JMP low operand or the branch offset
	always_ff @(posedge phi2) begin
		if (done) begin
			dl <= dat_i;
			if (cycle == t1) begin
				adl <= dat_i;
			end
		end
	end

	// The PC only moves on advance, so adr is steady for the whole request
	assign adr = pc;
	assign cyc = req;
	assign stb = req;
	assign we = 1'b0;

endmodule

/* verilog/pc_unit_top.sv */
module pc_unit_top import pc_pkg::*; #(
	parameter addr_t RESET_PC = 16'h0200
) (
	input logic phi2,
	input logic rst_n,
	input logic flag_c,
	input byte_t dat_i,
	input logic ack,
	output addr_t adr,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic sync,
	output addr_t pc
);

	cycle_t cycle;
	decode_t dec;
	logic advance;
	byte_t dl;
	byte_t adl;
	byte_t pcl;
	byte_t pch;

	pc_bus_if pcb ();

	assign pc = {pch, pcl};

	opcode_decode u_decode (
		.phi2(phi2),
		.rst_n(rst_n),
		.advance(advance),
		.cycle(cycle),
		.dat(dl),
		.dec(dec)
	);

	pc_control u_control (
		.phi2(phi2),
		.rst_n(rst_n),
		.advance(advance),
		.flag_c(flag_c),
		.dec(dec),
		.cycle(cycle),
		.sync(sync),
		.pcb(pcb.ctrl)
	);

	// The operand latch feeds both ADL and the branch offset
	pc_low #(
		.RESET_LOW(RESET_PC[7:0])
	) u_pcl (
		.phi2(phi2),
		.rst_n(rst_n),
		.advance(advance),
		.adl(adl),
		.offset(adl),
		.pcb(pcb.low),
		.pcl(pcl)
	);

	pc_high #(
		.RESET_HIGH(RESET_PC[15:8])
	) u_pch (
		.phi2(phi2),
		.rst_n(rst_n),
		.advance(advance),
		.dl(dl),
		.adh(pch),  // PCH drives ADH
		.pcb(pcb.high),
		.pch(pch)
	);

	bus_master u_bus (
		.phi2(phi2),
		.rst_n(rst_n),
		.pc(pc),
		.cycle(cycle),
		.adr(adr),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.ack(ack),
		.dat_i(dat_i),
		.dl(dl),
		.adl(adl),
		.advance(advance)
	);

endmodule

/* bench/pc_unit_mem.sv */
module pc_unit_mem import pc_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic waits_on,
	input addr_t adr,
	input logic cyc,
	input logic stb,
	input logic we,
	output byte_t dat_o,
	output logic ack
);

	timeunit 1ns;
	timeprecision 100ps;

	byte_t data [0:65535];
	logic [31:0] lfsr;
	logic [31:0] lfsr_one;
	logic [31:0] lfsr_two;
	logic busy;
	logic [1:0] wait_cnt;
	logic [1:0] waits;

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	assign lfsr_one = lfsr_step(lfsr);
	assign lfsr_two = lfsr_step(lfsr_one);
	assign waits = waits_on ? {lfsr_one[0], lfsr_two[0]} : 2'd0;    // One step per bit

	task automatic fill_pattern();
		for (int a = 0; a < 65536; a++) begin
			data[16'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'ha5;
		end
	endtask

	task automatic load_byte(input addr_t a, input byte_t d);
		data[a] = d;
	endtask

	function automatic byte_t read_byte(input addr_t a);
		return data[a];
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= 32'h6dccee87;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
			ack <= 1'b0;
			dat_o <= '0;
		end else if (ack) begin
			ack <= 1'b0;    // The master drops cyc on this same edge
			busy <= 1'b0;
		end else if (cyc && stb && !we) begin
			if (!busy) begin
				busy <= 1'b1;
				if (waits_on) begin
					lfsr <= lfsr_two;
				end
				if (waits == 2'd0) begin
					ack <= 1'b1;
					dat_o <= data[adr];
				end else begin
					wait_cnt <= waits - 2'd1;
				end
			end else if (wait_cnt == 2'd0) begin
				ack <= 1'b1;
				dat_o <= data[adr];
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

endmodule

/* bench/pc_unit_tb.sv */
module pc_unit_tb import pc_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam addr_t reset_pc = 16'h0200;
	localparam int reset_cycles = 10;
	localparam int runs = 7;
	localparam int max_accesses = 40;
	localparam int max_access_cycles = 3 + 3;   // Handshake plus up to three wait states
	localparam int watchdog_ns = runs * (reset_cycles + max_accesses * max_access_cycles) * 8;

	logic phi2 = 1'b0;
	logic rst_n;
	logic flag_c;
	logic waits_on;
	byte_t dat_i;
	logic ack;
	addr_t adr;
	logic cyc;
	logic stb;
	logic we;
	logic sync;
	addr_t pc;

	addr_t seen_adr[$];
	logic seen_sync[$];
	addr_t exp_adr[$];
	logic exp_sync[$];
	logic pending = 1'b0;
	addr_t held_adr;
	int stall_cycles = 0;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;

	always #4 phi2 = ~phi2;

	pc_unit_top #(
		.RESET_PC(reset_pc)
	) dut (
		.phi2(phi2),
		.rst_n(rst_n),
		.flag_c(flag_c),
		.dat_i(dat_i),
		.ack(ack),
		.adr(adr),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.sync(sync),
		.pc(pc)
	);

	pc_unit_mem u_mem (
		.clk(phi2),
		.rst_n(rst_n),
		.waits_on(waits_on),
		.adr(adr),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.dat_o(dat_i),
		.ack(ack)
	);

	task automatic check_adr(input string name, input addr_t actual, input addr_t expected);
		checks++;
		assert (actual == expected) else begin
			value_errors++;
			$display("** Error at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		checks++;
		assert (actual == expected) else begin
			value_errors++;
			$display("** Error at %0d ns: %s = %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			other_errors++;
			$display("Check failed at %0d ns: %s", $time, what);
		end
	endtask

	// Every access that ends in ack is logged, and a stalled request must hold adr
	always @(posedge phi2) begin
		if (rst_n && cyc && stb) begin
			check_bit("we", we, 1'b0);  // Every access is a read
			if (pending) begin
				check_adr("adr while ack low", adr, held_adr);
			end
			if (ack) begin
				seen_adr.push_back(adr);
				seen_sync.push_back(sync);
			end else if (pending) begin
				stall_cycles++;
			end
		end
		pending <= rst_n && cyc && stb && !ack;
		held_adr <= adr;
	end

	task automatic expect_access(input addr_t a, input logic fetch);
		exp_adr.push_back(a);
		exp_sync.push_back(fetch);
	endtask

	// Instruction-level model of the access trace
	task automatic model_run(input int n_instr);
		addr_t pc_m;
		addr_t after;
		addr_t target;
		opcode_t op;
		byte_t lo;
		logic taken;
		exp_adr.delete();
		exp_sync.delete();
		pc_m = reset_pc;
		repeat (n_instr) begin
			op = u_mem.read_byte(pc_m);
			lo = u_mem.read_byte(pc_m + 16'd1);
			after = pc_m + 16'd2;
			expect_access(pc_m, 1'b1);
			expect_access(pc_m + 16'd1, 1'b0);  // Each instruction reads the byte after its opcode
			if (op == op_jmp_abs) begin
				expect_access(after, 1'b0);
				pc_m = {u_mem.read_byte(after), lo};
			end else if (op == op_bcc || op == op_bcs) begin
				taken = (op == op_bcs) ? flag_c : !flag_c;
				if (taken) begin
					target = after + {{8{lo[7]}}, lo};
					expect_access(after, 1'b0);
					if (target[15:8] != after[15:8]) begin
						expect_access({after[15:8], target[7:0]}, 1'b0);
					end
					after = target;
				end
				pc_m = after;
			end else begin
				pc_m = pc_m + 16'd1;
			end
		end
	endtask

	task automatic assemble(input addr_t at, input opcode_t op, input addr_t operand);
		u_mem.load_byte(at, op);
		if (op == op_jmp_abs) begin
			u_mem.load_byte(at + 16'd1, operand[7:0]);
			u_mem.load_byte(at + 16'd2, operand[15:8]);
		end else if (op == op_bcc || op == op_bcs) begin
			u_mem.load_byte(at + 16'd1, operand[7:0]);
		end
	endtask

	task automatic apply_reset();
		@(posedge phi2);
		rst_n <= 1'b0;
		repeat (reset_cycles - 1) @(posedge phi2);
		@(negedge phi2);
		check_bit("cyc in reset", cyc, 1'b0);
		check_bit("stb in reset", stb, 1'b0);
		check_bit("sync in reset", sync, 1'b0);
		check_adr("pc in reset", pc, reset_pc);
		seen_adr.delete();
		seen_sync.delete();
		stall_cycles = 0;
		@(posedge phi2);
		rst_n <= 1'b1;
	endtask

	task automatic run_checked(input string name, input int n_instr);
		model_run(n_instr);
		while (seen_adr.size() < exp_adr.size()) @(posedge phi2);
		foreach (exp_adr[i]) begin
			check_adr($sformatf("%s adr[%0d]", name, i), seen_adr[i], exp_adr[i]);
			check_bit($sformatf("%s sync[%0d]", name, i), seen_sync[i], exp_sync[i]);
		end
	endtask

	task automatic test_reset_and_nops();
		for (int i = 0; i < 7; i++) begin
			assemble(reset_pc + 16'(i), op_nop, 16'h0000);
		end
		assemble(16'h0204, 8'h1a, 16'h0000);    // Unlisted opcode
		assemble(16'h0207, op_jmp_abs, 16'h0207);
		apply_reset();
		@(negedge phi2);
		check_bit("cyc after reset", cyc, 1'b0);
		@(negedge phi2);
		check_bit("cyc", cyc, 1'b1);
		check_bit("stb", stb, 1'b1);
		check_bit("sync", sync, 1'b1);
		check_adr("adr", adr, reset_pc);
		run_checked("nop", 9);
	endtask

	task automatic test_jmp();
		assemble(16'h0200, op_jmp_abs, 16'h0310);
		assemble(16'h0310, op_nop, 16'h0000);
		assemble(16'h0311, op_jmp_abs, 16'h04fe);
		assemble(16'h04fe, op_jmp_abs, 16'h0280);   // Operand bytes on both sides of the page
		assemble(16'h0280, op_jmp_abs, 16'h0280);
		apply_reset();
		run_checked("jmp", 5);
	endtask

	task automatic test_branch_sense(input logic carry);
		assemble(16'h0200, op_bcc, 16'h0004);
		assemble(16'h0202, op_bcs, 16'h0004);
		assemble(16'h0206, op_bcs, 16'h0010);
		assemble(16'h0208, op_nop, 16'h0000);
		assemble(16'h0209, op_jmp_abs, 16'h0209);
		@(posedge phi2);
		flag_c <= carry;
		apply_reset();
		run_checked(carry ? "branch c=1" : "branch c=0", 4);
	endtask

	task automatic test_page_cross();
		assemble(16'h0200, op_jmp_abs, 16'h02f0);
		assemble(16'h02f0, op_bcs, 16'h0020);   // Forward into page 03
		assemble(16'h0312, op_bcs, 16'h00e0);   // Back into page 02
		assemble(16'h02f4, op_nop, 16'h0000);
		assemble(16'h02f5, op_jmp_abs, 16'h02f5);
		@(posedge phi2);
		flag_c <= 1'b1;
		apply_reset();
		run_checked("page cross", 5);
	endtask

	// Runs the page-cross program again with and without wait states
	task automatic test_wait_states();
		addr_t quiet_adr[$];
		@(posedge phi2);
		waits_on <= 1'b0;
		apply_reset();
		run_checked("no waits", 5);
		check_true(stall_cycles == 0, "memory stalled with wait states off");
		quiet_adr = seen_adr;
		@(posedge phi2);
		waits_on <= 1'b1;
		apply_reset();
		run_checked("random waits", 5);
		check_true(stall_cycles > 0, "no wait state was inserted with wait states on");
		for (int i = 0; i < exp_adr.size(); i++) begin
			check_adr($sformatf("adr at ack %0d", i), seen_adr[i], quiet_adr[i]);
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired at %0d ns before the tests finished", $time);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		flag_c = 1'b0;
		waits_on = 1'b1;
		u_mem.fill_pattern();
		test_reset_and_nops();
		test_jmp();
		test_branch_sense(1'b0);
		test_branch_sense(1'b1);
		test_page_cross();
		test_wait_states();
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* list.f */
verilog/pc_pkg.sv
verilog/pc_bus_if.sv
verilog/opcode_decode.sv
verilog/pc_control.sv
verilog/pc_low.sv
verilog/pc_high.sv
verilog/bus_master.sv
verilog/pc_unit_top.sv
bench/pc_unit_mem.sv
bench/pc_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= pc_unit_tb
FILE_LIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
